// ==== build.f ====
rtl/axi_mem_pkg.sv
rtl/axi_mem_array.sv
rtl/axi_mem_burst_cnt.sv
rtl/axi_mem_monitor.sv
rtl/axi_mem_rd_ctrl.sv
rtl/axi_mem_wr_ctrl.sv
rtl/axi_mem_top.sv
tests/tb_axi_mem.sv

// ==== rtl/axi_mem_array.sv ====
/*
 * Memory word array
 * Byte-strobed write port and combinational read port, cleared on reset
 */
`timescale 1ns/1ps

module axi_mem_array
  import axi_mem_pkg::*;
#(
  parameter int DATA_WIDTH = 32,
  parameter int MEM_WORDS  = 256
) (
  input  logic                                            clk_i,
  input  logic                                            arst_n_i,
  input  logic                                            we_i,
  input  logic [((MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1)-1:0] waddr_i,
  input  logic [DATA_WIDTH-1:0]                           wdata_i,
  input  logic [DATA_WIDTH/AXI_BYTE_W-1:0]                wstrb_i,
  input  logic [((MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1)-1:0] raddr_i,
  output logic [DATA_WIDTH-1:0]                           rdata_o
);

  localparam int STRB_W = DATA_WIDTH / AXI_BYTE_W;

  logic [DATA_WIDTH-1:0] mem [MEM_WORDS];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int w = 0; w < MEM_WORDS; w++) begin
        mem[w] <= '0;
      end
    end else if (we_i) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (wstrb_i[b]) begin
          mem[waddr_i][b*AXI_BYTE_W +: AXI_BYTE_W] <= wdata_i[b*AXI_BYTE_W +: AXI_BYTE_W];
        end
      end
    end
  end

  // Index space may be larger than the array when MEM_WORDS is not a power of two
  assign rdata_o = (int'(raddr_i) < MEM_WORDS) ? mem[raddr_i] : '0;

endmodule

// ==== rtl/axi_mem_burst_cnt.sv ====
/*
 * Burst beat counter
 * Tracks beat index and word-aligned address of a FIXED or INCR burst
 * and flags the last beat and beats outside the memory
 */
`timescale 1ns/1ps

module axi_mem_burst_cnt
  import axi_mem_pkg::*;
#(
  parameter int DATA_WIDTH = 32,
  parameter int MEM_WORDS  = 256
) (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  load_i,
  input  logic                  step_i,
  input  logic [AXI_ADDR_W-1:0] addr_i,
  input  len_t                  len_i,
  input  burst_e                burst_i,
  output logic [AXI_ADDR_W-1:0] addr_o,
  output logic [((MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1)-1:0] word_o,
  output len_t                  beat_o,
  output logic                  last_o,
  output logic                  err_o
);

  localparam int STRB_W = DATA_WIDTH / AXI_BYTE_W;
  localparam int OFF_W  = (STRB_W > 1) ? $clog2(STRB_W) : 0;
  localparam int WORD_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

  logic [AXI_ADDR_W-1:0] addr_q;
  logic [AXI_ADDR_W-1:0] word_full;
  len_t                  beat_q;
  len_t                  len_q;
  burst_e                burst_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      addr_q  <= '0;
      beat_q  <= '0;
      len_q   <= '0;
      burst_q <= BURST_FIXED;
    end else if (load_i) begin
      // Only full-width beats, so drop the byte offset
      addr_q  <= addr_i & ~AXI_ADDR_W'(STRB_W - 1);
      beat_q  <= '0;
      len_q   <= len_i;
      burst_q <= burst_i;
    end else if (step_i) begin
      beat_q <= beat_q + len_t'(1);
      if (burst_q != BURST_FIXED) begin
        addr_q <= addr_q + AXI_ADDR_W'(STRB_W);
      end
    end
  end

  assign word_full = addr_q >> OFF_W;

  assign addr_o = addr_q;
  assign word_o = word_full[WORD_W-1:0];
  assign beat_o = beat_q;
  assign last_o = (beat_q == len_q);
  assign err_o  = (word_full >= AXI_ADDR_W'(MEM_WORDS));

endmodule

// ==== rtl/axi_mem_monitor.sv ====
/*
 * Beat monitor
 * Reports every accepted write and read beat one cycle after its handshake
 */
`timescale 1ns/1ps

module axi_mem_monitor
  import axi_mem_pkg::*;
#(
  parameter int DATA_WIDTH = 32,
  parameter int ID_WIDTH   = 4
) (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  w_fire_i,
  input  logic [AXI_ADDR_W-1:0] w_addr_i,
  input  logic [DATA_WIDTH-1:0] w_data_i,
  input  logic [ID_WIDTH-1:0]   w_id_i,
  input  len_t                  w_beat_i,
  input  logic                  w_last_i,
  input  logic                  r_fire_i,
  input  logic [AXI_ADDR_W-1:0] r_addr_i,
  input  logic [DATA_WIDTH-1:0] r_data_i,
  input  logic [ID_WIDTH-1:0]   r_id_i,
  input  len_t                  r_beat_i,
  input  logic                  r_last_i,
  output logic                  mon_w_valid_o,
  output logic [AXI_ADDR_W-1:0] mon_w_addr_o,
  output logic [DATA_WIDTH-1:0] mon_w_data_o,
  output logic [ID_WIDTH-1:0]   mon_w_id_o,
  output len_t                  mon_w_beat_o,
  output logic                  mon_w_last_o,
  output logic                  mon_r_valid_o,
  output logic [AXI_ADDR_W-1:0] mon_r_addr_o,
  output logic [DATA_WIDTH-1:0] mon_r_data_o,
  output logic [ID_WIDTH-1:0]   mon_r_id_o,
  output len_t                  mon_r_beat_o,
  output logic                  mon_r_last_o
);

  // One-cycle valid pulse per accepted beat
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mon_w_valid_o <= 1'b0;
      mon_r_valid_o <= 1'b0;
    end else begin
      mon_w_valid_o <= w_fire_i;
      mon_r_valid_o <= r_fire_i;
    end
  end

  // Write beat capture
  always_ff @(posedge clk_i) begin
    if (w_fire_i) begin
      mon_w_addr_o <= w_addr_i;
      mon_w_data_o <= w_data_i;
      mon_w_id_o   <= w_id_i;
      mon_w_beat_o <= w_beat_i;
      mon_w_last_o <= w_last_i;
    end
  end

  // Read beat capture
  always_ff @(posedge clk_i) begin
    if (r_fire_i) begin
      mon_r_addr_o <= r_addr_i;
      mon_r_data_o <= r_data_i;
      mon_r_id_o   <= r_id_i;
      mon_r_beat_o <= r_beat_i;
      mon_r_last_o <= r_last_i;
    end
  end

endmodule

// ==== rtl/axi_mem_pkg.sv ====
/*
 * AXI memory package
 * Shared AXI constants, burst length type and the burst and response encodings
 */

package axi_mem_pkg;

  // Fixed AXI4 field widths
  localparam int AXI_ADDR_W = 32;
  localparam int AXI_LEN_W  = 8;

  // Bits per strobe lane
  localparam int AXI_BYTE_W = 8;

  // Burst length field, also used as beat index
  typedef logic [AXI_LEN_W-1:0] len_t;

  // AXI burst type encoding
  typedef enum logic [1:0] {
    BURST_FIXED = 2'd0,
    BURST_INCR  = 2'd1,
    BURST_WRAP  = 2'd2   // stepped like INCR here
  } burst_e;

  // Only the two responses this slave can produce
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'd0,
    RESP_SLVERR = 2'd2
  } resp_e;

endpackage

// ==== rtl/axi_mem_rd_ctrl.sv ====
/*
 * AXI memory read controller
 * Takes one AR burst at a time and streams its beats on R,
 * advancing only when the master accepts a beat
 */
`timescale 1ns/1ps

module axi_mem_rd_ctrl
  import axi_mem_pkg::*;
#(
  parameter int ID_WIDTH = 4
) (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                arvalid_i,
  input  logic [ID_WIDTH-1:0] arid_i,
  input  logic                rready_i,
  input  logic                beat_last_i,
  input  logic                beat_err_i,
  output logic                arready_o,
  output logic                rvalid_o,
  output logic [ID_WIDTH-1:0] rid_o,
  output resp_e               rresp_o,
  output logic                rlast_o,
  output logic                cnt_load_o,
  output logic                cnt_step_o,
  output logic                mon_fire_o
);

  typedef enum logic {
    RD_IDLE,
    RD_DATA
  } rd_state_e;

  rd_state_e           state_q;
  rd_state_e           state_d;
  logic [ID_WIDTH-1:0] id_q;
  logic                ar_hs;
  logic                r_hs;

  assign arready_o = (state_q == RD_IDLE);
  assign rvalid_o  = (state_q == RD_DATA);

  assign ar_hs = arvalid_i & arready_o;
  assign r_hs  = rvalid_o & rready_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      RD_IDLE: if (ar_hs) state_d = RD_DATA;
      RD_DATA: if (r_hs && beat_last_i) state_d = RD_IDLE;
      default: state_d = RD_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= RD_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ar_hs) begin
      id_q <= arid_i;
    end
  end

  // Beat payload follows the counter, so it holds while the master stalls
  assign rid_o   = id_q;
  assign rresp_o = beat_err_i ? RESP_SLVERR : RESP_OKAY;
  assign rlast_o = rvalid_o & beat_last_i;

  assign cnt_load_o = ar_hs;
  assign cnt_step_o = r_hs;
  assign mon_fire_o = r_hs;

endmodule

// ==== rtl/axi_mem_top.sv ====
/*
 * AXI4 slave memory
 * One full AXI4 port over a byte-strobed register array, with independent
 * write and read burst engines and a beat monitor
 */
`timescale 1ns/1ps

module axi_mem_top
  import axi_mem_pkg::*;
#(
  parameter int DATA_WIDTH = 32,
  parameter int ID_WIDTH   = 4,
  parameter int MEM_WORDS  = 256
) (
  input  logic                           clk_i,
  input  logic                           arst_n_i,
  // AW channel
  input  logic                           awvalid_i,
  output logic                           awready_o,
  input  logic [AXI_ADDR_W-1:0]          awaddr_i,
  input  len_t                           awlen_i,
  input  burst_e                         awburst_i,
  input  logic [ID_WIDTH-1:0]            awid_i,
  // W channel
  input  logic                           wvalid_i,
  output logic                           wready_o,
  input  logic [DATA_WIDTH-1:0]          wdata_i,
  input  logic [DATA_WIDTH/AXI_BYTE_W-1:0] wstrb_i,
  input  logic                           wlast_i,
  // B channel
  output logic                           bvalid_o,
  input  logic                           bready_i,
  output logic [ID_WIDTH-1:0]            bid_o,
  output resp_e                          bresp_o,
  // AR channel
  input  logic                           arvalid_i,
  output logic                           arready_o,
  input  logic [AXI_ADDR_W-1:0]          araddr_i,
  input  len_t                           arlen_i,
  input  burst_e                         arburst_i,
  input  logic [ID_WIDTH-1:0]            arid_i,
  // R channel
  output logic                           rvalid_o,
  input  logic                           rready_i,
  output logic [DATA_WIDTH-1:0]          rdata_o,
  output logic [ID_WIDTH-1:0]            rid_o,
  output resp_e                          rresp_o,
  output logic                           rlast_o,
  // Beat monitor
  output logic                           mon_w_valid_o,
  output logic [AXI_ADDR_W-1:0]          mon_w_addr_o,
  output logic [DATA_WIDTH-1:0]          mon_w_data_o,
  output logic [ID_WIDTH-1:0]            mon_w_id_o,
  output len_t                           mon_w_beat_o,
  output logic                           mon_w_last_o,
  output logic                           mon_r_valid_o,
  output logic [AXI_ADDR_W-1:0]          mon_r_addr_o,
  output logic [DATA_WIDTH-1:0]          mon_r_data_o,
  output logic [ID_WIDTH-1:0]            mon_r_id_o,
  output len_t                           mon_r_beat_o,
  output logic                           mon_r_last_o
);

  localparam int STRB_W = DATA_WIDTH / AXI_BYTE_W;
  localparam int WORD_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

  // Write path
  logic                  wr_load, wr_step, wr_last, wr_err;
  logic [AXI_ADDR_W-1:0] wr_addr;
  logic [WORD_W-1:0]     wr_word;
  len_t                  wr_beat;
  logic                  mem_we;
  logic [STRB_W-1:0]     mem_strb;
  logic                  w_fire;
  logic [ID_WIDTH-1:0]   w_id;

  // Read path
  logic                  rd_load, rd_step, rd_last, rd_err;
  logic [AXI_ADDR_W-1:0] rd_addr;
  logic [WORD_W-1:0]     rd_word;
  len_t                  rd_beat;
  logic                  r_fire;

  // wlast_i is not checked, the write burst ends on the beat count

  axi_mem_wr_ctrl #(
    .DATA_WIDTH(DATA_WIDTH),
    .ID_WIDTH  (ID_WIDTH)
  ) u_wr_ctrl (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .awvalid_i  (awvalid_i),
    .awid_i     (awid_i),
    .wvalid_i   (wvalid_i),
    .wstrb_i    (wstrb_i),
    .bready_i   (bready_i),
    .beat_last_i(wr_last),
    .beat_err_i (wr_err),
    .awready_o  (awready_o),
    .wready_o   (wready_o),
    .bvalid_o   (bvalid_o),
    .bid_o      (bid_o),
    .bresp_o    (bresp_o),
    .cnt_load_o (wr_load),
    .cnt_step_o (wr_step),
    .mem_we_o   (mem_we),
    .mem_strb_o (mem_strb),
    .mon_fire_o (w_fire),
    .mon_id_o   (w_id)
  );

  axi_mem_burst_cnt #(
    .DATA_WIDTH(DATA_WIDTH),
    .MEM_WORDS (MEM_WORDS)
  ) u_wr_cnt (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .load_i  (wr_load),
    .step_i  (wr_step),
    .addr_i  (awaddr_i),
    .len_i   (awlen_i),
    .burst_i (awburst_i),
    .addr_o  (wr_addr),
    .word_o  (wr_word),
    .beat_o  (wr_beat),
    .last_o  (wr_last),
    .err_o   (wr_err)
  );

  axi_mem_rd_ctrl #(
    .ID_WIDTH(ID_WIDTH)
  ) u_rd_ctrl (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .arvalid_i  (arvalid_i),
    .arid_i     (arid_i),
    .rready_i   (rready_i),
    .beat_last_i(rd_last),
    .beat_err_i (rd_err),
    .arready_o  (arready_o),
    .rvalid_o   (rvalid_o),
    .rid_o      (rid_o),
    .rresp_o    (rresp_o),
    .rlast_o    (rlast_o),
    .cnt_load_o (rd_load),
    .cnt_step_o (rd_step),
    .mon_fire_o (r_fire)
  );

  axi_mem_burst_cnt #(
    .DATA_WIDTH(DATA_WIDTH),
    .MEM_WORDS (MEM_WORDS)
  ) u_rd_cnt (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .load_i  (rd_load),
    .step_i  (rd_step),
    .addr_i  (araddr_i),
    .len_i   (arlen_i),
    .burst_i (arburst_i),
    .addr_o  (rd_addr),
    .word_o  (rd_word),
    .beat_o  (rd_beat),
    .last_o  (rd_last),
    .err_o   (rd_err)
  );

  axi_mem_array #(
    .DATA_WIDTH(DATA_WIDTH),
    .MEM_WORDS (MEM_WORDS)
  ) u_array (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .we_i    (mem_we),
    .waddr_i (wr_word),
    .wdata_i (wdata_i),
    .wstrb_i (mem_strb),
    .raddr_i (rd_word),
    .rdata_o (rdata_o)
  );

  axi_mem_monitor #(
    .DATA_WIDTH(DATA_WIDTH),
    .ID_WIDTH  (ID_WIDTH)
  ) u_monitor (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .w_fire_i     (w_fire),
    .w_addr_i     (wr_addr),
    .w_data_i     (wdata_i),
    .w_id_i       (w_id),
    .w_beat_i     (wr_beat),
    .w_last_i     (wr_last),
    .r_fire_i     (r_fire),
    .r_addr_i     (rd_addr),
    .r_data_i     (rdata_o),
    .r_id_i       (rid_o),
    .r_beat_i     (rd_beat),
    .r_last_i     (rlast_o),
    .mon_w_valid_o(mon_w_valid_o),
    .mon_w_addr_o (mon_w_addr_o),
    .mon_w_data_o (mon_w_data_o),
    .mon_w_id_o   (mon_w_id_o),
    .mon_w_beat_o (mon_w_beat_o),
    .mon_w_last_o (mon_w_last_o),
    .mon_r_valid_o(mon_r_valid_o),
    .mon_r_addr_o (mon_r_addr_o),
    .mon_r_data_o (mon_r_data_o),
    .mon_r_id_o   (mon_r_id_o),
    .mon_r_beat_o (mon_r_beat_o),
    .mon_r_last_o (mon_r_last_o)
  );

endmodule

// ==== rtl/axi_mem_wr_ctrl.sv ====
/*
 * AXI memory write controller
 * Takes one AW burst at a time, writes each W beat into the array and
 * answers with a single B response carrying the burst's range error
 */
`timescale 1ns/1ps

module axi_mem_wr_ctrl
  import axi_mem_pkg::*;
#(
  parameter int DATA_WIDTH = 32,
  parameter int ID_WIDTH   = 4
) (
  input  logic                           clk_i,
  input  logic                           arst_n_i,
  input  logic                           awvalid_i,
  input  logic [ID_WIDTH-1:0]            awid_i,
  input  logic                           wvalid_i,
  input  logic [DATA_WIDTH/AXI_BYTE_W-1:0] wstrb_i,
  input  logic                           bready_i,
  input  logic                           beat_last_i,
  input  logic                           beat_err_i,
  output logic                           awready_o,
  output logic                           wready_o,
  output logic                           bvalid_o,
  output logic [ID_WIDTH-1:0]            bid_o,
  output resp_e                          bresp_o,
  output logic                           cnt_load_o,
  output logic                           cnt_step_o,
  output logic                           mem_we_o,
  output logic [DATA_WIDTH/AXI_BYTE_W-1:0] mem_strb_o,
  output logic                           mon_fire_o,
  output logic [ID_WIDTH-1:0]            mon_id_o
);

  localparam int STRB_W = DATA_WIDTH / AXI_BYTE_W;

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_DATA,
    WR_RESP
  } wr_state_e;

  wr_state_e           state_q;
  wr_state_e           state_d;
  logic [ID_WIDTH-1:0] id_q;
  logic                err_q;
  logic                aw_hs;
  logic                w_hs;
  logic                b_hs;

  assign awready_o = (state_q == WR_IDLE);
  assign wready_o  = (state_q == WR_DATA);
  assign bvalid_o  = (state_q == WR_RESP);

  assign aw_hs = awvalid_i & awready_o;
  assign w_hs  = wvalid_i & wready_o;
  assign b_hs  = bvalid_o & bready_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      WR_IDLE: if (aw_hs) state_d = WR_DATA;
      WR_DATA: if (w_hs && beat_last_i) state_d = WR_RESP;
      WR_RESP: if (b_hs) state_d = WR_IDLE;
      default: state_d = WR_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= WR_IDLE;
      err_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      // Sticky over the burst, restarted by the next AW
      if (aw_hs) begin
        err_q <= 1'b0;
      end else if (w_hs) begin
        err_q <= err_q | beat_err_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (aw_hs) begin
      id_q <= awid_i;
    end
  end

  assign cnt_load_o = aw_hs;
  assign cnt_step_o = w_hs;

  // Out of range beats are accepted but leave the array untouched
  assign mem_we_o   = w_hs & ~beat_err_i;
  assign mem_strb_o = wstrb_i & {STRB_W{w_hs}};

  assign bid_o    = id_q;
  assign bresp_o  = err_q ? RESP_SLVERR : RESP_OKAY;

  assign mon_fire_o = w_hs;
  assign mon_id_o   = id_q;

endmodule

// ==== run.sh ====
#!/bin/sh
# Compile and run the AXI memory testbench with Verilator
rm -f sim.log &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_axi_mem \
  -f build.f -o tb_axi_mem > build.log 2>&1 &&
./obj_dir/tb_axi_mem > sim.log 2>&1 ||
echo "build or simulation stopped with an error"
grep -qs "All checks passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== tests/tb_axi_mem.sv ====
/*
 * Testbench for the AXI4 slave memory
 * Applies a table of write and read bursts under random back-pressure and
 * checks responses, read data and the beat monitor against a byte model
 */
`timescale 1ns/1ps

module tb_axi_mem
  import axi_mem_pkg::*;
();

  localparam int DATA_W  = 32;
  localparam int ID_W    = 4;
  localparam int WORDS   = 256;
  localparam int STRB_W  = DATA_W / 8;
  localparam int OFF_W   = 2;
  localparam int TIMEOUT = 1000;
  localparam int NUM_TXN = 17;
  localparam logic [AXI_ADDR_W-1:0] ALIGN_MASK = ~AXI_ADDR_W'(STRB_W - 1);

  typedef struct packed {
    logic                  is_write;
    logic [AXI_ADDR_W-1:0] addr;
    len_t                  len;
    burst_e                burst;
    logic [ID_W-1:0]       id;
    logic [STRB_W-1:0]     strb;
    resp_e                 resp;
  } txn_t;

  logic                  clk;
  logic                  arst_n;
  logic                  awvalid;
  logic                  awready;
  logic [AXI_ADDR_W-1:0] awaddr;
  len_t                  awlen;
  burst_e                awburst;
  logic [ID_W-1:0]       awid;
  logic                  wvalid;
  logic                  wready;
  logic [DATA_W-1:0]     wdata;
  logic [STRB_W-1:0]     wstrb;
  logic                  wlast;
  logic                  bvalid;
  logic                  bready;
  logic [ID_W-1:0]       bid;
  resp_e                 bresp;
  logic                  arvalid;
  logic                  arready;
  logic [AXI_ADDR_W-1:0] araddr;
  len_t                  arlen;
  burst_e                arburst;
  logic [ID_W-1:0]       arid;
  logic                  rvalid;
  logic                  rready;
  logic [DATA_W-1:0]     rdata;
  logic [ID_W-1:0]       rid;
  resp_e                 rresp;
  logic                  rlast;
  logic                  mon_w_valid;
  logic [AXI_ADDR_W-1:0] mon_w_addr;
  logic [DATA_W-1:0]     mon_w_data;
  logic [ID_W-1:0]       mon_w_id;
  len_t                  mon_w_beat;
  logic                  mon_w_last;
  logic                  mon_r_valid;
  logic [AXI_ADDR_W-1:0] mon_r_addr;
  logic [DATA_W-1:0]     mon_r_data;
  logic [ID_W-1:0]       mon_r_id;
  len_t                  mon_r_beat;
  logic                  mon_r_last;

  // Reference byte memory and stimulus state
  logic [7:0]  model [WORDS*STRB_W];
  txn_t        txns [NUM_TXN];
  logic [31:0] rng_state;

  // State of the pin-level checker process
  logic                  pend_w, pend_r, er_chk, hold_r, hold_b;
  logic [AXI_ADDR_W-1:0] w_addr, r_addr, ew_addr, er_addr;
  len_t                  w_len, r_len, w_beat, r_beat, ew_beat, er_beat;
  burst_e                w_burst, r_burst;
  logic [ID_W-1:0]       w_id, r_id, ew_id, er_id, hr_id, hb_id;
  logic [DATA_W-1:0]     ew_data, er_data, hr_data;
  logic                  ew_last, er_last, hr_last;
  resp_e                 hr_resp, hb_resp;

  axi_mem_top uut (
    .clk_i(clk), .arst_n_i(arst_n),
    .awvalid_i(awvalid), .awready_o(awready), .awaddr_i(awaddr), .awlen_i(awlen),
    .awburst_i(awburst), .awid_i(awid),
    .wvalid_i(wvalid), .wready_o(wready), .wdata_i(wdata), .wstrb_i(wstrb),
    .wlast_i(wlast),
    .bvalid_o(bvalid), .bready_i(bready), .bid_o(bid), .bresp_o(bresp),
    .arvalid_i(arvalid), .arready_o(arready), .araddr_i(araddr), .arlen_i(arlen),
    .arburst_i(arburst), .arid_i(arid),
    .rvalid_o(rvalid), .rready_i(rready), .rdata_o(rdata), .rid_o(rid),
    .rresp_o(rresp), .rlast_o(rlast),
    .mon_w_valid_o(mon_w_valid), .mon_w_addr_o(mon_w_addr), .mon_w_data_o(mon_w_data),
    .mon_w_id_o(mon_w_id), .mon_w_beat_o(mon_w_beat), .mon_w_last_o(mon_w_last),
    .mon_r_valid_o(mon_r_valid), .mon_r_addr_o(mon_r_addr), .mon_r_data_o(mon_r_data),
    .mon_r_id_o(mon_r_id), .mon_r_beat_o(mon_r_beat), .mon_r_last_o(mon_r_last)
  );

  always #50 clk = ~clk;

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("Checks failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    $display("mismatch %s got 0x%0h expected 0x%0h", name, got, exp);
    $display("Checks failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_wait(inout int cycles, input string what);
    cycles++;
    if (cycles > TIMEOUT) begin
      report_error({"timeout waiting for ", what});
    end
  endtask

  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // Ready high three cycles out of four
  function automatic logic random_ready();
    return (next_random() & 32'd3) != 32'd0;
  endfunction

  // Base strobe rotated left by the beat index
  function automatic logic [STRB_W-1:0] beat_strobe(input logic [STRB_W-1:0] base,
                                                    input int beat);
    logic [STRB_W-1:0] s;
    for (int b = 0; b < STRB_W; b++) begin
      s[(b + beat) % STRB_W] = base[b];
    end
    return s;
  endfunction

  function automatic logic [DATA_W-1:0] model_word(input logic [AXI_ADDR_W-1:0] word);
    logic [DATA_W-1:0] w;
    for (int b = 0; b < STRB_W; b++) begin
      w[8*b +: 8] = model[int'(word) * STRB_W + b];
    end
    return w;
  endfunction

  // Operation, address, len, burst, ID, strobe, burst response
  task automatic load_table();
    txns[0]  = '{1'b1, 32'h0000_0010, 8'd7,   BURST_INCR,  4'h3, 4'hf, RESP_OKAY};
    txns[1]  = '{1'b0, 32'h0000_0010, 8'd7,   BURST_INCR,  4'h5, 4'h0, RESP_OKAY};
    txns[2]  = '{1'b1, 32'h0000_0102, 8'd15,  BURST_INCR,  4'h9, 4'h5, RESP_OKAY};
    txns[3]  = '{1'b0, 32'h0000_0100, 8'd15,  BURST_INCR,  4'h1, 4'h0, RESP_OKAY};
    txns[4]  = '{1'b1, 32'h0000_0020, 8'd3,   BURST_INCR,  4'h2, 4'h3, RESP_OKAY};
    txns[5]  = '{1'b0, 32'h0000_0008, 8'd9,   BURST_INCR,  4'h2, 4'h0, RESP_OKAY};
    txns[6]  = '{1'b1, 32'h0000_0200, 8'd3,   BURST_FIXED, 4'h6, 4'hf, RESP_OKAY};
    txns[7]  = '{1'b0, 32'h0000_0202, 8'd3,   BURST_FIXED, 4'h7, 4'h0, RESP_OKAY};
    // Bursts running past the end of the array
    txns[8]  = '{1'b1, 32'h0000_03f0, 8'd7,   BURST_INCR,  4'ha, 4'hf, RESP_SLVERR};
    txns[9]  = '{1'b0, 32'h0000_03f0, 8'd7,   BURST_INCR,  4'hb, 4'h0, RESP_SLVERR};
    txns[10] = '{1'b0, 32'h0000_0000, 8'd11,  BURST_INCR,  4'h4, 4'h0, RESP_OKAY};
    txns[11] = '{1'b1, 32'h0000_0300, 8'd63,  BURST_INCR,  4'hc, 4'h6, RESP_OKAY};
    txns[12] = '{1'b0, 32'h0000_02fc, 8'd70,  BURST_INCR,  4'hd, 4'h0, RESP_SLVERR};
    txns[13] = '{1'b1, 32'h0000_00fc, 8'd0,   BURST_INCR,  4'h1, 4'ha, RESP_OKAY};
    txns[14] = '{1'b0, 32'h0000_00fc, 8'd0,   BURST_FIXED, 4'h2, 4'h0, RESP_OKAY};
    txns[15] = '{1'b1, 32'h0000_0400, 8'd1,   BURST_FIXED, 4'he, 4'hf, RESP_SLVERR};
    txns[16] = '{1'b0, 32'h0000_0000, 8'd255, BURST_INCR,  4'hf, 4'h0, RESP_OKAY};
  endtask

  task automatic run_write(input txn_t t);
    int                    cycles;
    logic [AXI_ADDR_W-1:0] addr;
    logic [AXI_ADDR_W-1:0] word;
    logic [DATA_W-1:0]     data;
    logic [STRB_W-1:0]     strb;
    logic                  any_err;
    addr = t.addr & ALIGN_MASK;
    any_err = 1'b0;
    @(posedge clk);
    awvalid <= 1'b1;
    awaddr  <= t.addr;
    awlen   <= t.len;
    awburst <= t.burst;
    awid    <= t.id;
    cycles = 0;
    @(posedge clk);
    while (!awready) begin
      check_wait(cycles, "awready");
      @(posedge clk);
    end
    awvalid <= 1'b0;
    for (int beat = 0; beat <= int'(t.len); beat++) begin
      data = next_random();
      strb = beat_strobe(t.strb, beat);
      wvalid <= 1'b1;
      wdata  <= data;
      wstrb  <= strb;
      wlast  <= (beat == int'(t.len));
      cycles = 0;
      @(posedge clk);
      while (!wready) begin
        check_wait(cycles, "wready");
        @(posedge clk);
      end
      // Beat taken on this edge
      // Out of range beats leave the model alone
      word = addr >> OFF_W;
      if (word < WORDS) begin
        for (int b = 0; b < STRB_W; b++) begin
          if (strb[b]) begin
            model[int'(word) * STRB_W + b] = data[8*b +: 8];
          end
        end
      end else begin
        any_err = 1'b1;
      end
      if (t.burst != BURST_FIXED) begin
        addr = addr + AXI_ADDR_W'(STRB_W);
      end
    end
    wvalid <= 1'b0;
    wlast  <= 1'b0;
    bready <= random_ready();
    @(posedge clk);
    assert (bvalid && !wready) else report_error("B not raised right after the last W beat");
    cycles = 0;
    while (!(bvalid && bready)) begin
      check_wait(cycles, "B handshake");
      bready <= random_ready();
      @(posedge clk);
    end
    assert (bid == t.id) else report_mismatch("bid", bid, t.id);
    assert (bresp == t.resp) else report_mismatch("bresp", bresp, t.resp);
    assert (any_err == (t.resp == RESP_SLVERR))
      else report_error("write table response disagrees with the range rule");
    bready <= 1'b0;
  endtask

  task automatic run_read(input txn_t t);
    int                    cycles;
    logic [AXI_ADDR_W-1:0] addr;
    logic [AXI_ADDR_W-1:0] word;
    logic                  err;
    logic                  any_err;
    resp_e                 exp_resp;
    addr = t.addr & ALIGN_MASK;
    any_err = 1'b0;
    @(posedge clk);
    arvalid <= 1'b1;
    araddr  <= t.addr;
    arlen   <= t.len;
    arburst <= t.burst;
    arid    <= t.id;
    cycles = 0;
    @(posedge clk);
    while (!arready) begin
      check_wait(cycles, "arready");
      @(posedge clk);
    end
    arvalid <= 1'b0;
    rready  <= random_ready();
    for (int beat = 0; beat <= int'(t.len); beat++) begin
      cycles = 0;
      @(posedge clk);
      while (!(rvalid && rready)) begin
        check_wait(cycles, "R beat");
        rready <= random_ready();
        @(posedge clk);
      end
      word = addr >> OFF_W;
      err = (word >= WORDS);
      exp_resp = err ? RESP_SLVERR : RESP_OKAY;
      assert (rid == t.id) else report_mismatch("rid", rid, t.id);
      assert (rresp == exp_resp) else report_mismatch("rresp", rresp, exp_resp);
      assert (rlast == (beat == int'(t.len)))
        else report_mismatch("rlast", rlast, beat == int'(t.len));
      if (!err) begin
        assert (rdata == model_word(word)) else report_mismatch("rdata", rdata, model_word(word));
      end
      any_err = any_err | err;
      rready <= random_ready();
      if (t.burst != BURST_FIXED) begin
        addr = addr + AXI_ADDR_W'(STRB_W);
      end
    end
    rready <= 1'b0;
    @(posedge clk);
    assert (!rvalid && arready) else report_error("read burst did not end after rlast");
    assert (any_err == (t.resp == RESP_SLVERR))
      else report_error("read table response disagrees with the range rule");
  endtask

  // Payload hold under back-pressure and monitor beats tracked from the pins
  always @(posedge clk) begin
    if (arst_n) begin
      if (hold_r) begin
        assert (rvalid) else report_error("rvalid dropped while rready was low");
        assert (rdata == hr_data) else report_mismatch("rdata", rdata, hr_data);
        assert (rid == hr_id) else report_mismatch("rid", rid, hr_id);
        assert (rresp == hr_resp) else report_mismatch("rresp", rresp, hr_resp);
        assert (rlast == hr_last) else report_mismatch("rlast", rlast, hr_last);
      end
      if (hold_b) begin
        assert (bvalid) else report_error("bvalid dropped while bready was low");
        assert (bid == hb_id) else report_mismatch("bid", bid, hb_id);
        assert (bresp == hb_resp) else report_mismatch("bresp", bresp, hb_resp);
      end
      assert (mon_w_valid == pend_w) else report_mismatch("mon_w_valid", mon_w_valid, pend_w);
      if (pend_w) begin
        assert (mon_w_addr == ew_addr) else report_mismatch("mon_w_addr", mon_w_addr, ew_addr);
        assert (mon_w_data == ew_data) else report_mismatch("mon_w_data", mon_w_data, ew_data);
        assert (mon_w_id == ew_id) else report_mismatch("mon_w_id", mon_w_id, ew_id);
        assert (mon_w_beat == ew_beat) else report_mismatch("mon_w_beat", mon_w_beat, ew_beat);
        assert (mon_w_last == ew_last) else report_mismatch("mon_w_last", mon_w_last, ew_last);
      end
      assert (mon_r_valid == pend_r) else report_mismatch("mon_r_valid", mon_r_valid, pend_r);
      if (pend_r) begin
        assert (mon_r_addr == er_addr) else report_mismatch("mon_r_addr", mon_r_addr, er_addr);
        assert (mon_r_id == er_id) else report_mismatch("mon_r_id", mon_r_id, er_id);
        assert (mon_r_beat == er_beat) else report_mismatch("mon_r_beat", mon_r_beat, er_beat);
        assert (mon_r_last == er_last) else report_mismatch("mon_r_last", mon_r_last, er_last);
        if (er_chk) begin
          assert (mon_r_data == er_data) else report_mismatch("mon_r_data", mon_r_data, er_data);
        end
      end
      if (awvalid && awready) begin
        w_addr  = awaddr & ALIGN_MASK;
        w_len   = awlen;
        w_burst = awburst;
        w_id    = awid;
        w_beat  = '0;
      end
      pend_w = wvalid && wready;
      if (pend_w) begin
        ew_addr = w_addr;
        ew_data = wdata;
        ew_id   = w_id;
        ew_beat = w_beat;
        ew_last = (w_beat == w_len);
        w_beat  = w_beat + len_t'(1);
        if (w_burst != BURST_FIXED) begin
          w_addr = w_addr + AXI_ADDR_W'(STRB_W);
        end
      end
      if (arvalid && arready) begin
        r_addr  = araddr & ALIGN_MASK;
        r_len   = arlen;
        r_burst = arburst;
        r_id    = arid;
        r_beat  = '0;
      end
      pend_r = rvalid && rready;
      if (pend_r) begin
        er_addr = r_addr;
        er_chk  = ((r_addr >> OFF_W) < WORDS);
        er_data = er_chk ? model_word(r_addr >> OFF_W) : '0;
        er_id   = r_id;
        er_beat = r_beat;
        er_last = (r_beat == r_len);
        r_beat  = r_beat + len_t'(1);
        if (r_burst != BURST_FIXED) begin
          r_addr = r_addr + AXI_ADDR_W'(STRB_W);
        end
      end
      hold_r  = rvalid && !rready;
      hr_data = rdata;
      hr_id   = rid;
      hr_resp = rresp;
      hr_last = rlast;
      hold_b  = bvalid && !bready;
      hb_id   = bid;
      hb_resp = bresp;
    end
  end

  initial begin
    clk     = 1'b0;
    arst_n  = 1'b0;
    awvalid = 1'b0;
    awaddr  = '0;
    awlen   = '0;
    awburst = BURST_INCR;
    awid    = '0;
    wvalid  = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wlast   = 1'b0;
    bready  = 1'b0;
    arvalid = 1'b0;
    araddr  = '0;
    arlen   = '0;
    arburst = BURST_INCR;
    arid    = '0;
    rready  = 1'b0;
    pend_w  = 1'b0;
    pend_r  = 1'b0;
    hold_r  = 1'b0;
    hold_b  = 1'b0;
    rng_state = 32'hb3e967d6;
    for (int i = 0; i < WORDS * STRB_W; i++) begin
      model[i] = 8'h00;
    end
    load_table();
    repeat (16) @(posedge clk);
    arst_n <= 1'b1;
    @(posedge clk);
    // Idle state straight after reset
    assert (awready && arready) else report_error("awready or arready low after reset");
    assert (!wready && !bvalid && !rvalid)
      else report_error("channel valid or wready high after reset");
    assert (!mon_w_valid && !mon_r_valid) else report_error("monitor valid high after reset");
    for (int i = 0; i < NUM_TXN; i++) begin
      if (txns[i].is_write) begin
        run_write(txns[i]);
      end else begin
        run_read(txns[i]);
      end
    end
    repeat (2) @(posedge clk);
    $display("All checks passed");
    $finish;
  end

endmodule
